/* snake_pkg.sv */
`default_nettype none

package snake_pkg;

	////////////////////////////////////////
	// basic types
	////////////////////////////////////////

	typedef logic [5:0]  tile_t;       // tile coordinate, pixel counter bits 10:5
	typedef logic [11:0] pixel_cnt_t;  // raw video counter
	typedef logic [7:0]  colour_t;     // one colour component

	// bit 1 set means the snake moves vertically
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_UP    = 2'b10,
		DIR_DOWN  = 2'b11
	} dir_t;

	////////////////////////////////////////
	// grid layout
	////////////////////////////////////////

	localparam tile_t FIELD_MIN = 6'd1;   // first tile the head may occupy
	localparam tile_t FIELD_MAX = 6'd13;  // last tile the head may occupy
	localparam tile_t WALL_LO   = 6'd0;
	localparam tile_t WALL_HI   = 6'd14;

	localparam tile_t APPLE_X = 6'd10;  // apple never moves
	localparam tile_t APPLE_Y = 6'd10;

	localparam tile_t START_X = 6'd2;  // head position after reset
	localparam tile_t START_Y = 6'd12;

	////////////////////////////////////////
	// flat tile colours
	////////////////////////////////////////

	localparam colour_t WALL_R  = 8'hb0;  // brick red
	localparam colour_t WALL_G  = 8'h40;
	localparam colour_t WALL_B  = 8'h20;
	localparam colour_t BODY_R  = 8'h30;  // snake green
	localparam colour_t BODY_G  = 8'hc0;
	localparam colour_t BODY_B  = 8'h50;
	localparam colour_t APPLE_R = 8'he0;
	localparam colour_t APPLE_G = 8'h10;
	localparam colour_t APPLE_B = 8'h10;

endpackage

`default_nettype wire

/* snake_if.sv */
`default_nettype none

// head moves from the motion unit, one strobe per tick
interface snake_step_if import snake_pkg::*; ();
	logic  step;    // one-cycle strobe, head still old while high
	logic  grow;    // next head lands on the apple, only valid with step
	tile_t head_x;
	tile_t head_y;

	modport mover (output step, output grow, output head_x, output head_y);
	modport body  (input step, input grow, input head_x, input head_y);
	modport view  (input head_x, input head_y);
endinterface

// segment history as seen by the renderer
interface snake_view_if import snake_pkg::*; #(
	parameter int MAX_LEN = 16
) ();
	localparam int LEN_W = $clog2(MAX_LEN);

	tile_t            seg_x [1:MAX_LEN-1];
	tile_t            seg_y [1:MAX_LEN-1];
	logic [LEN_W-1:0] length;  // visible segments behind the head
	logic             bitten;

	modport store (output seg_x, output seg_y, output length, output bitten);
	modport draw  (input seg_x, input seg_y, input length, input bitten);
endinterface

`default_nettype wire

/* snake_motion.sv */
`default_nettype none

module snake_motion import snake_pkg::*; #(
	parameter int TICK_CYCLES = 74_250_000
) (
	input  wire logic    i_clk_74M,
	input  wire logic    i_rst_n,
	input  wire logic    i_btn_r,
	input  wire logic    i_btn_l,
	input  wire logic    i_btn_u,
	input  wire logic    i_btn_d,
	snake_step_if.mover  o_step_bus
);

	localparam int CNT_W = $clog2(TICK_CYCLES);

	dir_t             dir;
	logic [CNT_W-1:0] tick_cnt;
	logic             step;
	tile_t            head_x;
	tile_t            head_y;
	tile_t            nxt_x;
	tile_t            nxt_y;

	////////////////////////////////////////
	// direction, no reversing allowed
	////////////////////////////////////////

	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			dir <= DIR_RIGHT;
		end else if (i_btn_r && dir[1]) begin  // only from vertical
			dir <= DIR_RIGHT;
		end else if (i_btn_l && dir[1]) begin
			dir <= DIR_LEFT;
		end else if (i_btn_d && !dir[1]) begin  // only from horizontal
			dir <= DIR_DOWN;
		end else if (i_btn_u && !dir[1]) begin
			dir <= DIR_UP;
		end
	end

	////////////////////////////////////////
	// tick generator
	////////////////////////////////////////

	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			tick_cnt <= '0;
			step     <= 1'b0;
		end else if (tick_cnt == CNT_W'(TICK_CYCLES - 1)) begin
			tick_cnt <= '0;
			step     <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			step     <= 1'b0;
		end
	end

	// next head tile with wrap inside the walls
	always_comb begin
		nxt_x = head_x;
		nxt_y = head_y;
		case (dir)
			DIR_RIGHT: nxt_x = (head_x >= FIELD_MAX) ? FIELD_MIN : head_x + 1'b1;
			DIR_LEFT:  nxt_x = (head_x <= FIELD_MIN) ? FIELD_MAX : head_x - 1'b1;
			DIR_DOWN:  nxt_y = (head_y >= FIELD_MAX) ? FIELD_MIN : head_y + 1'b1;
			DIR_UP:    nxt_y = (head_y <= FIELD_MIN) ? FIELD_MAX : head_y - 1'b1;
			default:   nxt_x = head_x;
		endcase
	end

	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			head_x <= START_X;
			head_y <= START_Y;
		end else if (step) begin  // new head visible the cycle after the strobe
			head_x <= nxt_x;
			head_y <= nxt_y;
		end
	end

	assign o_step_bus.step   = step;
	assign o_step_bus.grow   = step && (nxt_x == APPLE_X) && (nxt_y == APPLE_Y);
	assign o_step_bus.head_x = head_x;
	assign o_step_bus.head_y = head_y;

endmodule

`default_nettype wire

/* snake_body_store.sv */
`default_nettype none

module snake_body_store import snake_pkg::*; #(
	parameter int MAX_LEN = 16
) (
	input  wire logic    i_clk_74M,
	input  wire logic    i_rst_n,
	snake_step_if.body   i_step_bus,
	snake_view_if.store  o_view_bus
);

	localparam int LEN_W = $clog2(MAX_LEN);

	tile_t            seg_x [1:MAX_LEN-1];
	tile_t            seg_y [1:MAX_LEN-1];
	logic [LEN_W-1:0] length;
	logic [LEN_W-1:0] scan_idx;  // 0 while idle
	logic             bitten;

	////////////////////////////////////////
	// segment history
	////////////////////////////////////////

	always_ff @(posedge i_clk_74M) begin
		if (i_step_bus.step) begin
			seg_x[1] <= i_step_bus.head_x;  // old head becomes first segment
			seg_y[1] <= i_step_bus.head_y;
			for (int i = 2; i < MAX_LEN; i++) begin
				seg_x[i] <= seg_x[i-1];
				seg_y[i] <= seg_y[i-1];
			end
		end
	end

	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			length <= '0;
		end else if (i_step_bus.grow && length != LEN_W'(MAX_LEN - 1)) begin
			length <= length + 1'b1;  // saturates at the store depth
		end
	end

	////////////////////////////////////////
	// self-bite scan
	////////////////////////////////////////

	// one segment per cycle against the new head
	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			scan_idx <= '0;
			bitten   <= 1'b0;
		end else if (i_step_bus.step) begin
			scan_idx <= LEN_W'(1);
			bitten   <= 1'b0;  // each step starts clean
		end else if (scan_idx != '0) begin
			if (scan_idx <= length &&
				seg_x[scan_idx] == i_step_bus.head_x &&
				seg_y[scan_idx] == i_step_bus.head_y) begin
				bitten <= 1'b1;
			end
			if (scan_idx == LEN_W'(MAX_LEN - 1)) begin
				scan_idx <= '0;  // whole store covered
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	assign o_view_bus.seg_x  = seg_x;
	assign o_view_bus.seg_y  = seg_y;
	assign o_view_bus.length = length;
	assign o_view_bus.bitten = bitten;

endmodule

`default_nettype wire

/* tile_renderer.sv */
`default_nettype none

module tile_renderer import snake_pkg::*; #(
	parameter int MAX_LEN = 16
) (
	input  wire logic       i_clk_74M,
	input  wire logic       i_rst_n,
	input  wire pixel_cnt_t i_hcnt,
	input  wire pixel_cnt_t i_vcnt,
	snake_step_if.view      i_step_bus,
	snake_view_if.draw      i_view_bus,
	output colour_t         o_r,
	output colour_t         o_g,
	output colour_t         o_b
);

	tile_t   tile_x;
	tile_t   tile_y;
	logic    wall_hit;
	logic    head_hit;
	logic    body_hit;
	colour_t nxt_r;
	colour_t nxt_g;
	colour_t nxt_b;

	assign tile_x = i_hcnt[10:5];  // 32-pixel tiles
	assign tile_y = i_vcnt[10:5];

	assign wall_hit = (tile_x <= WALL_HI) && (tile_y <= WALL_HI) &&
		(tile_x == WALL_LO || tile_x == WALL_HI || tile_y == WALL_LO || tile_y == WALL_HI);
	assign head_hit = (tile_x == i_step_bus.head_x) && (tile_y == i_step_bus.head_y);

	// every segment compared in parallel
	always_comb begin
		body_hit = 1'b0;
		for (int i = 1; i < MAX_LEN; i++) begin
			if (i <= i_view_bus.length && i_view_bus.seg_x[i] == tile_x &&
				i_view_bus.seg_y[i] == tile_y) begin
				body_hit = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// colour priority
	////////////////////////////////////////

	always_comb begin
		{nxt_r, nxt_g, nxt_b} = '0;  // black background
		if (wall_hit) begin
			{nxt_r, nxt_g, nxt_b} = {WALL_R, WALL_G, WALL_B};
		end else if (head_hit && i_view_bus.bitten) begin
			{nxt_r, nxt_g, nxt_b} = {BODY_G, BODY_B, BODY_R};  // rotated on a bite
		end else if (head_hit || body_hit) begin
			{nxt_r, nxt_g, nxt_b} = {BODY_R, BODY_G, BODY_B};
		end else if (tile_x == APPLE_X && tile_y == APPLE_Y) begin
			{nxt_r, nxt_g, nxt_b} = {APPLE_R, APPLE_G, APPLE_B};
		end
	end

	always_ff @(posedge i_clk_74M) begin
		if (!i_rst_n) begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end else begin
			o_r <= nxt_r;  // one cycle behind the counters
			o_g <= nxt_g;
			o_b <= nxt_b;
		end
	end

endmodule

`default_nettype wire

/* snake_game.sv */
`default_nettype none

module snake_game import snake_pkg::*; #(
	parameter int MAX_LEN     = 16,
	parameter int TICK_CYCLES = 74_250_000
) (
	input  wire logic       i_clk_74M,
	input  wire logic       i_rst_n,
	input  wire pixel_cnt_t i_hcnt,   // from the video timing generator
	input  wire pixel_cnt_t i_vcnt,
	input  wire logic       i_btn_r,
	input  wire logic       i_btn_l,
	input  wire logic       i_btn_u,
	input  wire logic       i_btn_d,
	output colour_t         o_r,
	output colour_t         o_g,
	output colour_t         o_b
);

	snake_step_if                     step_bus ();
	snake_view_if #(.MAX_LEN(MAX_LEN)) view_bus ();

	snake_motion #(
		.TICK_CYCLES (TICK_CYCLES)
	) motion_inst (
		.i_clk_74M  (i_clk_74M),
		.i_rst_n    (i_rst_n),
		.i_btn_r    (i_btn_r),
		.i_btn_l    (i_btn_l),
		.i_btn_u    (i_btn_u),
		.i_btn_d    (i_btn_d),
		.o_step_bus (step_bus.mover)
	);

	snake_body_store #(
		.MAX_LEN (MAX_LEN)
	) body_inst (
		.i_clk_74M  (i_clk_74M),
		.i_rst_n    (i_rst_n),
		.i_step_bus (step_bus.body),
		.o_view_bus (view_bus.store)
	);

	tile_renderer #(
		.MAX_LEN (MAX_LEN)
	) render_inst (
		.i_clk_74M  (i_clk_74M),
		.i_rst_n    (i_rst_n),
		.i_hcnt     (i_hcnt),
		.i_vcnt     (i_vcnt),
		.i_step_bus (step_bus.view),
		.i_view_bus (view_bus.draw),
		.o_r        (o_r),
		.o_g        (o_g),
		.o_b        (o_b)
	);

endmodule

`default_nettype wire

/* snake_game_chk.sv */
`default_nettype none

module snake_game_chk import snake_pkg::*; #(
	parameter int MAX_LEN = 16
) (
	input wire logic                       i_clk_74M,
	input wire logic                       i_rst_n,
	input wire logic                       i_step,
	input wire logic                       i_grow,
	input wire tile_t                      i_head_x,
	input wire tile_t                      i_head_y,
	input wire logic [$clog2(MAX_LEN)-1:0] i_length
);
	timeunit 1ns;
	timeprecision 1ps;

	step_pulse: assert property (@(posedge i_clk_74M) disable iff (!i_rst_n)
		i_step |=> !i_step)
		else $error("step strobe held for more than one cycle");

	// new head shows up one cycle after the strobe
	grow_with_step: assert property (@(posedge i_clk_74M) disable iff (!i_rst_n)
		i_grow |-> i_step ##1 (i_head_x == APPLE_X && i_head_y == APPLE_Y))
		else $error("grow raised without a step onto the apple");

	head_in_field: assert property (@(posedge i_clk_74M) disable iff (!i_rst_n)
		i_head_x >= FIELD_MIN && i_head_x <= FIELD_MAX &&
		i_head_y >= FIELD_MIN && i_head_y <= FIELD_MAX)
		else $error("head left the field");

	// a saturating length never drops, a wrap past the top would
	length_bound: assert property (@(posedge i_clk_74M) disable iff (!i_rst_n)
		i_length >= $past(i_length))
		else $error("body length wrapped past the store depth");

endmodule

bind snake_game snake_game_chk #(
	.MAX_LEN (MAX_LEN)
) chk_inst (
	.i_clk_74M (i_clk_74M),
	.i_rst_n   (i_rst_n),
	.i_step    (step_bus.step),
	.i_grow    (step_bus.grow),
	.i_head_x  (step_bus.head_x),
	.i_head_y  (step_bus.head_y),
	.i_length  (view_bus.length)
);

`default_nettype wire

/* tb_snake_game.sv */
`default_nettype none

module tb_snake_game import snake_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          MAX_LEN     = 8;
	localparam int          TICK_CYCLES = 400;
	localparam int          NUM_STEPS   = 72;
	localparam int          BTN_LEAD    = 100;  // press this many cycles before a step
	localparam int          TILES       = 15;   // tiles 0 to 14 in both axes
	localparam int unsigned RAND_SEED   = 32'h6e81_bd99;
	localparam longint      WATCHDOG_NS = longint'(NUM_STEPS + 2) * TICK_CYCLES * 8;
	localparam logic [3:0]  BTN_R       = 4'b1000;  // {r, l, u, d}
	localparam logic [3:0]  BTN_L       = 4'b0100;
	localparam logic [3:0]  BTN_U       = 4'b0010;
	localparam logic [3:0]  BTN_D       = 4'b0001;

	logic       i_clk_74M;
	logic       i_rst_n;
	pixel_cnt_t i_hcnt;
	pixel_cnt_t i_vcnt;
	logic [3:0] btn;
	colour_t    o_r;
	colour_t    o_g;
	colour_t    o_b;

	dir_t m_dir;  // reference model of the game state
	int   m_hx;
	int   m_hy;
	int   m_len;
	int   m_sx [1:MAX_LEN-1];
	int   m_sy [1:MAX_LEN-1];
	logic m_bit;

	logic sweep_valid;
	logic chk_valid;
	int   sweep_x;
	int   sweep_y;
	int   chk_x;
	int   chk_y;
	int   edge_idx;  // rising edges since reset release
	int   err_cnt;
	int   chk_cnt;

	snake_game #(
		.MAX_LEN     (MAX_LEN),
		.TICK_CYCLES (TICK_CYCLES)
	) snake_game_inst (
		.i_clk_74M (i_clk_74M),
		.i_rst_n   (i_rst_n),
		.i_hcnt    (i_hcnt),
		.i_vcnt    (i_vcnt),
		.i_btn_r   (btn[3]),
		.i_btn_l   (btn[2]),
		.i_btn_u   (btn[1]),
		.i_btn_d   (btn[0]),
		.o_r       (o_r),
		.o_g       (o_g),
		.o_b       (o_b)
	);

	initial begin
		i_clk_74M = 1'b0;
		forever #4 i_clk_74M = ~i_clk_74M;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// first button in priority order that turns onto the other axis
	function automatic dir_t next_dir(dir_t d, logic [3:0] b);
		logic vertical;
		vertical = (d == DIR_UP || d == DIR_DOWN);
		if (b[3] && vertical)
			return DIR_RIGHT;
		if (b[2] && vertical)
			return DIR_LEFT;
		if (b[0] && !vertical)
			return DIR_DOWN;
		if (b[1] && !vertical)
			return DIR_UP;
		return d;
	endfunction

	function automatic int wrap_move(int c, int delta);
		int n;
		n = c + delta;
		if (n > 13)
			n = 1;
		if (n < 1)
			n = 13;
		return n;
	endfunction

	task automatic model_step();
		int nx;
		int ny;
		nx = m_hx;
		ny = m_hy;
		case (m_dir)
			DIR_RIGHT: nx = wrap_move(m_hx, 1);
			DIR_LEFT:  nx = wrap_move(m_hx, -1);
			DIR_DOWN:  ny = wrap_move(m_hy, 1);
			default:   ny = wrap_move(m_hy, -1);
		endcase
		for (int i = MAX_LEN - 1; i > 1; i--) begin
			m_sx[i] = m_sx[i-1];
			m_sy[i] = m_sy[i-1];
		end
		m_sx[1] = m_hx;  // old head trails directly behind
		m_sy[1] = m_hy;
		if (nx == 10 && ny == 10 && m_len < MAX_LEN - 1)
			m_len++;
		m_hx  = nx;
		m_hy  = ny;
		m_bit = 1'b0;
		for (int i = 1; i <= m_len; i++) begin
			if (m_sx[i] == m_hx && m_sy[i] == m_hy)
				m_bit = 1'b1;
		end
	endtask

	function automatic logic [23:0] ref_rgb(int x, int y);
		logic body;
		body = 1'b0;
		for (int i = 1; i <= m_len; i++) begin
			if (m_sx[i] == x && m_sy[i] == y)
				body = 1'b1;
		end
		if (x <= 14 && y <= 14 && (x == 0 || x == 14 || y == 0 || y == 14))
			return {WALL_R, WALL_G, WALL_B};
		if (x == m_hx && y == m_hy)
			return m_bit ? {BODY_G, BODY_B, BODY_R} : {BODY_R, BODY_G, BODY_B};
		if (body)
			return {BODY_R, BODY_G, BODY_B};
		if (x == 10 && y == 10)
			return {APPLE_R, APPLE_G, APPLE_B};
		return 24'h0;
	endfunction

	// straight run with wrap, then apple laps, then random turns
	function automatic logic [3:0] pick_buttons(int s);
		if (s == 22)
			return BTN_U;
		if (s >= 24 && s <= 51) begin
			case ((s - 24) % 4)
				0:       return BTN_R;
				1:       return BTN_D;
				2:       return BTN_L;
				default: return BTN_U;
			endcase
		end
		if (s < 54)
			return 4'b0000;
		case ($urandom % 4)
			0:       return 4'b0000;
			3:       return 4'($urandom);  // several buttons at once
			default: return BTN_D << ($urandom % 4);
		endcase
	endfunction

	task automatic next_edge();
		@(posedge i_clk_74M);
		edge_idx++;
	endtask

	task automatic wait_edge(int k);
		while (edge_idx < k)
			next_edge();
	endtask

	task automatic sweep_tiles();
		for (int n = 0; n < TILES * TILES; n++) begin
			sweep_valid <= 1'b1;
			sweep_x     <= n % TILES;
			sweep_y     <= n / TILES;
			i_hcnt      <= {1'b0, 6'(n % TILES), 5'($urandom)};  // any pixel inside the tile
			i_vcnt      <= {1'b0, 6'(n / TILES), 5'($urandom)};
			next_edge();
		end
		sweep_valid <= 1'b0;
	endtask

	////////////////////////////////////////
	// compare
	////////////////////////////////////////

	always @(posedge i_clk_74M) begin
		chk_valid <= sweep_valid;  // same one-cycle delay as the RGB register
		chk_x     <= sweep_x;
		chk_y     <= sweep_y;
	end

	always @(negedge i_clk_74M) begin
		logic [23:0] exp_rgb;
		if (chk_valid) begin
			exp_rgb = ref_rgb(chk_x, chk_y);
			chk_cnt++;
			if ({o_r, o_g, o_b} !== exp_rgb) begin
				err_cnt++;
				$display("error at %0d ns: tile (%0d,%0d) shows %h, expected %h",
					$time, chk_x, chk_y, {o_r, o_g, o_b}, exp_rgb);
			end
		end
	end

	initial begin
		logic [3:0] btn_code;
		void'($urandom(RAND_SEED));
		i_rst_n     = 1'b0;
		i_hcnt      = '0;
		i_vcnt      = '0;
		btn         = '0;
		sweep_valid = 1'b0;
		chk_valid   = 1'b0;
		sweep_x     = 0;
		sweep_y     = 0;
		edge_idx    = 0;
		err_cnt     = 0;
		chk_cnt     = 0;
		m_dir       = DIR_RIGHT;
		m_hx        = 2;
		m_hy        = 12;
		m_len       = 0;
		m_bit       = 1'b0;
		repeat (3) @(posedge i_clk_74M);
		i_rst_n <= 1'b1;
		@(negedge i_clk_74M);
		if ({o_r, o_g, o_b} !== 24'h0) begin
			err_cnt++;
			$display("error at %0d ns: RGB is not black in reset", $time);
		end
		wait_edge(2);
		sweep_tiles();  // reset frame
		for (int s = 1; s <= NUM_STEPS; s++) begin
			wait_edge(s * TICK_CYCLES - BTN_LEAD);
			btn_code = pick_buttons(s);
			btn     <= btn_code;  // held for one sampling edge only
			m_dir    = next_dir(m_dir, btn_code);
			next_edge();
			btn <= '0;
			wait_edge(s * TICK_CYCLES + 1);  // head moves on this edge
			model_step();
			wait_edge(s * TICK_CYCLES + MAX_LEN + 3);
			sweep_tiles();
		end
		wait_edge(edge_idx + 2);
		if (chk_cnt != (NUM_STEPS + 1) * TILES * TILES) begin
			err_cnt++;
			$display("not every tile was checked, only %0d of %0d",
				chk_cnt, (NUM_STEPS + 1) * TILES * TILES);
		end
		$display("%0d tile checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* snake_game.f */
snake_pkg.sv
snake_if.sv
snake_motion.sv
snake_body_store.sv
tile_renderer.sv
snake_game.sv
snake_game_chk.sv
tb_snake_game.sv

/* Bender.yml */
package:
  name: snake_game

sources:
  - snake_pkg.sv
  - snake_if.sv
  - snake_motion.sv
  - snake_body_store.sv
  - tile_renderer.sv
  - snake_game.sv
  - target: simulation
    files:
      - snake_game_chk.sv
      - tb_snake_game.sv
